// ==== axi_master/axi_master_bridge.sv ====
module axi_master_bridge
  import rv_core_pkg::*, axi_bus_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      req_valid_i,
  input  req_kind_e req_kind_i,
  input  req_id_t   req_id_i,
  input  axi_addr_t req_addr_i,
  input  axi_data_t req_wdata_i,
  input  axi_strb_t req_wstrb_i,
  axi_bus_if.master bus,
  output logic      rd_done_o,
  output axi_data_t rd_data_o,
  output req_id_t   rd_id_o,
  output logic      wr_done_o
);

  typedef enum logic [1:0] {
    st_idle,
    st_addr,
    st_data,
    st_resp
  } state_e;

  state_e    state_q;
  logic      is_wr_q;
  logic      ar_valid_q;
  logic      aw_valid_q;
  logic      w_valid_q;
  logic      rd_done_q;
  logic      wr_done_q;
  axi_addr_t addr_q;
  axi_data_t wdata_q;
  axi_strb_t wstrb_q;
  req_id_t   id_q;
  axi_data_t rd_data_q;
  req_id_t   rd_id_q;
  logic      ar_hs;
  logic      r_hs;
  logic      b_hs;
  logic      aw_left;
  logic      w_left;
  logic      start;

  assign ar_hs   = bus.ar_valid & bus.ar_ready;
  assign r_hs    = bus.r_valid & bus.r_ready;
  assign b_hs    = bus.b_valid & bus.b_ready;
  // write channels may be taken on different edges
  assign aw_left = aw_valid_q & ~bus.aw_ready;
  assign w_left  = w_valid_q & ~bus.w_ready;
  assign start   = (state_q == st_idle) & req_valid_i & (req_kind_i != req_none);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= st_idle;
      is_wr_q    <= 1'b0;
      ar_valid_q <= 1'b0;
      aw_valid_q <= 1'b0;
      w_valid_q  <= 1'b0;
      rd_done_q  <= 1'b0;
      wr_done_q  <= 1'b0;
    end else begin
      // completions trail the last handshake by one cycle
      rd_done_q <= r_hs & bus.r_last;
      wr_done_q <= b_hs;
      case (state_q)
        st_idle: begin
          if (start) begin
            is_wr_q    <= (req_kind_i == req_data_wr);
            ar_valid_q <= (req_kind_i != req_data_wr);
            aw_valid_q <= (req_kind_i == req_data_wr);
            w_valid_q  <= (req_kind_i == req_data_wr);
            state_q    <= st_addr;
          end
        end
        st_addr: begin
          if (!is_wr_q) begin
            if (ar_hs) begin
              ar_valid_q <= 1'b0;
              state_q    <= st_data;
            end
          end else begin
            aw_valid_q <= aw_left;
            w_valid_q  <= w_left;
            if (!aw_left && !w_left) begin
              state_q <= st_resp;
            end
          end
        end
        st_data: begin
          if (r_hs && bus.r_last) begin
            state_q <= st_idle;
          end
        end
        default: begin
          if (b_hs) begin
            state_q <= st_idle;
          end
        end
      endcase
    end
  end

  // request payload and returned read data
  always_ff @(posedge clk) begin
    if (start) begin
      addr_q  <= req_addr_i;
      wdata_q <= req_wdata_i;
      wstrb_q <= req_wstrb_i;
      id_q    <= req_id_i;
    end
    if (r_hs) begin
      // error reads return zero
      rd_data_q <= (bus.r_resp == axi_resp_okay) ? bus.r_data : '0;
      rd_id_q   <= bus.r_id;
    end
  end

  assign bus.ar_valid = ar_valid_q;
  assign bus.ar_addr  = addr_q;
  assign bus.ar_id    = id_q;
  assign bus.r_ready  = (state_q == st_data);
  assign bus.aw_valid = aw_valid_q;
  assign bus.aw_addr  = addr_q;
  assign bus.w_valid  = w_valid_q;
  assign bus.w_data   = wdata_q;
  assign bus.w_strb   = wstrb_q;
  // single beat writes
  assign bus.w_last   = 1'b1;
  assign bus.b_ready  = (state_q == st_resp);

  assign rd_done_o = rd_done_q;
  assign rd_data_o = rd_data_q;
  assign rd_id_o   = rd_id_q;
  assign wr_done_o = wr_done_q;

endmodule

// ==== axi_slave/axi_sram_slave.sv ====
`include "fetch_cfg.svh"

module axi_sram_slave
  import axi_bus_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  axi_bus_if.slave bus
);

  localparam int unsigned idx_w = $clog2(`FETCH_MEM_WORDS);

  axi_data_t        mem_q [`FETCH_MEM_WORDS];
  logic             r_valid_q;
  logic             b_valid_q;
  axi_data_t        r_data_q;
  axi_id_t          r_id_q;
  logic [idx_w-1:0] rd_idx;
  logic [idx_w-1:0] wr_idx;
  logic             ar_hs;
  logic             wr_take;

  // word index above the byte offset, upper bits wrap
  assign rd_idx  = bus.ar_addr[idx_w+2:3];
  assign wr_idx  = bus.aw_addr[idx_w+2:3];
  assign ar_hs   = bus.ar_valid & bus.ar_ready;
  // address and data taken together, not while bresp pending
  assign wr_take = bus.aw_valid & bus.w_valid & ~b_valid_q;

  // new read only once the previous beat left
  assign bus.ar_ready = ~r_valid_q;
  assign bus.aw_ready = wr_take;
  assign bus.w_ready  = wr_take;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      r_valid_q <= 1'b0;
      b_valid_q <= 1'b0;
    end else begin
      // r beat held under back-pressure
      if (ar_hs) begin
        r_valid_q <= 1'b1;
      end else if (bus.r_ready) begin
        r_valid_q <= 1'b0;
      end
      if (wr_take) begin
        b_valid_q <= 1'b1;
      end else if (bus.b_ready) begin
        b_valid_q <= 1'b0;
      end
    end
  end

  // synchronous read at the ar handshake
  always_ff @(posedge clk) begin
    if (ar_hs) begin
      r_data_q <= mem_q[rd_idx];
      r_id_q   <= bus.ar_id;
    end
  end

  // bytewise merge under strobe
  always_ff @(posedge clk) begin
    if (wr_take && bus.w_last) begin
      for (int i = 0; i < axi_strb_w; i++) begin
        if (bus.w_strb[i]) begin
          mem_q[wr_idx][8*i +: 8] <= bus.w_data[8*i +: 8];
        end
      end
    end
  end

  assign bus.r_valid = r_valid_q;
  assign bus.r_data  = r_data_q;
  // id echoed back, always okay
  assign bus.r_id    = r_id_q;
  assign bus.r_resp  = axi_resp_okay;
  assign bus.r_last  = 1'b1;
  assign bus.b_valid = b_valid_q;

endmodule

// ==== common/axi_bus_if.sv ====
interface axi_bus_if
  import axi_bus_pkg::*;
();

  // read address
  logic      ar_valid;
  logic      ar_ready;
  axi_addr_t ar_addr;
  axi_id_t   ar_id;

  // read data, single beat so r_last is always set
  logic      r_valid;
  logic      r_ready;
  axi_data_t r_data;
  axi_resp_t r_resp;
  logic      r_last;
  axi_id_t   r_id;

  // write address
  logic      aw_valid;
  logic      aw_ready;
  axi_addr_t aw_addr;

  // write data
  logic      w_valid;
  logic      w_ready;
  axi_data_t w_data;
  axi_strb_t w_strb;
  logic      w_last;

  // write response
  logic      b_valid;
  logic      b_ready;

  modport master (
    output ar_valid, ar_addr, ar_id, r_ready,
    output aw_valid, aw_addr, w_valid, w_data, w_strb, w_last, b_ready,
    input  ar_ready, r_valid, r_data, r_resp, r_last, r_id,
    input  aw_ready, w_ready, b_valid
  );

  modport slave (
    input  ar_valid, ar_addr, ar_id, r_ready,
    input  aw_valid, aw_addr, w_valid, w_data, w_strb, w_last, b_ready,
    output ar_ready, r_valid, r_data, r_resp, r_last, r_id,
    output aw_ready, w_ready, b_valid
  );

endinterface

// ==== common/axi_bus_pkg.sv ====
package axi_bus_pkg;

  // single 64-bit axi4 port, no bursts
  localparam int unsigned axi_addr_w = 64;
  localparam int unsigned axi_data_w = 64;
  localparam int unsigned axi_strb_w = axi_data_w / 8;
  localparam int unsigned axi_id_w   = 4;

  typedef logic [axi_addr_w-1:0] axi_addr_t;
  typedef logic [axi_data_w-1:0] axi_data_t;

  // one bit per byte lane
  typedef logic [axi_strb_w-1:0] axi_strb_t;

  // rresp / bresp encoding
  typedef logic [1:0] axi_resp_t;

  // same width as the core request tag
  typedef logic [axi_id_w-1:0] axi_id_t;

  localparam axi_resp_t axi_resp_okay   = 2'b00;
  localparam axi_resp_t axi_resp_exokay = 2'b01;
  localparam axi_resp_t axi_resp_slverr = 2'b10;
  localparam axi_resp_t axi_resp_decerr = 2'b11;

endpackage

// ==== common/fetch_cfg.svh ====
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// first pc after reset, start of ram
`define FETCH_RESET_PC 64'h0000_0000_8000_0000

// sram depth in 64-bit words, index from addr[12:3]
`define FETCH_MEM_WORDS 1024

// addi x0, x0, 0
`define FETCH_NOP_INST 32'h0000_0013

`endif

// ==== common/rv_core_pkg.sv ====
package rv_core_pkg;

  // fetch pc and data byte address share one type
  typedef logic [63:0] pc_t;

  // one rv32/rv64 instruction word
  typedef logic [31:0] inst_t;

  // transaction tag carried on ar_id
  typedef logic [3:0] req_id_t;

  // fetch takes id 1 and data takes id 2
  localparam req_id_t req_id_fetch = 4'd1;
  localparam req_id_t req_id_data  = 4'd2;

  // what the arbiter handed to the bus bridge
  typedef enum logic [1:0] {
    req_none,
    req_fetch_rd,
    req_data_rd,
    req_data_wr
  } req_kind_e;

endpackage

// ==== compile.f ====
+incdir+common
common/rv_core_pkg.sv
common/axi_bus_pkg.sv
common/axi_bus_if.sv
src/pc_sequencer.sv
src/mem_req_arbiter.sv
axi_master/axi_master_bridge.sv
axi_slave/axi_sram_slave.sv
src/resp_router.sv
src/fetch_stage_top.sv
tests/tb_fetch_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_fetch_stage -f compile.f -o tb_fetch_stage \
  && ./obj_dir/tb_fetch_stage > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Test OK" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== src/fetch_stage_top.sv ====
module fetch_stage_top
  import rv_core_pkg::*, axi_bus_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      fetch_en_i,
  input  logic      redirect_i,
  input  pc_t       redirect_pc_i,
  input  logic      data_rd_req_i,
  input  logic      data_wr_req_i,
  input  pc_t       data_addr_i,
  input  axi_data_t data_wdata_i,
  input  axi_strb_t data_wstrb_i,
  output logic      fetch_valid_o,
  output pc_t       fetch_pc_o,
  output inst_t     fetch_inst_o,
  output logic      data_rvalid_o,
  output axi_data_t data_rdata_o,
  output logic      data_wdone_o
);

  // sequencer <-> arbiter
  logic      fetch_req;
  pc_t       fetch_pc;
  logic      fetch_grant;
  logic      fetch_accept;
  logic      kill;

  // arbiter -> bridge
  logic      req_valid;
  req_kind_e req_kind;
  req_id_t   req_id;
  axi_addr_t req_addr;
  axi_data_t req_wdata;
  axi_strb_t req_wstrb;

  // bridge completions
  logic      rd_done;
  axi_data_t rd_data;
  req_id_t   rd_id;
  logic      wr_done;

  axi_bus_if axi_bus ();

  pc_sequencer u_pc_sequencer (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_en_i     (fetch_en_i),
    .redirect_i     (redirect_i),
    .redirect_pc_i  (redirect_pc_i),
    .fetch_grant_i  (fetch_grant),
    .fetch_accept_i (fetch_accept),
    .fetch_req_o    (fetch_req),
    .fetch_pc_o     (fetch_pc),
    .kill_o         (kill)
  );

  mem_req_arbiter u_mem_req_arbiter (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch_req_i   (fetch_req),
    .fetch_pc_i    (fetch_pc),
    .data_rd_req_i (data_rd_req_i),
    .data_wr_req_i (data_wr_req_i),
    .data_addr_i   (data_addr_i),
    .data_wdata_i  (data_wdata_i),
    .data_wstrb_i  (data_wstrb_i),
    .rd_done_i     (rd_done),
    .wr_done_i     (wr_done),
    .fetch_grant_o (fetch_grant),
    .data_grant_o  (),
    .req_valid_o   (req_valid),
    .req_kind_o    (req_kind),
    .req_id_o      (req_id),
    .req_addr_o    (req_addr),
    .req_wdata_o   (req_wdata),
    .req_wstrb_o   (req_wstrb)
  );

  axi_master_bridge u_axi_master_bridge (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid_i (req_valid),
    .req_kind_i  (req_kind),
    .req_id_i    (req_id),
    .req_addr_i  (req_addr),
    .req_wdata_i (req_wdata),
    .req_wstrb_i (req_wstrb),
    .bus         (axi_bus.master),
    .rd_done_o   (rd_done),
    .rd_data_o   (rd_data),
    .rd_id_o     (rd_id),
    .wr_done_o   (wr_done)
  );

  axi_sram_slave u_axi_sram_slave (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (axi_bus.slave)
  );

  resp_router u_resp_router (
    .clk            (clk),
    .rst_n          (rst_n),
    .rd_done_i      (rd_done),
    .rd_data_i      (rd_data),
    .rd_id_i        (rd_id),
    .wr_done_i      (wr_done),
    .kill_i         (kill),
    .fetch_pc_i     (fetch_pc),
    .fetch_accept_o (fetch_accept),
    .fetch_valid_o  (fetch_valid_o),
    .fetch_pc_o     (fetch_pc_o),
    .fetch_inst_o   (fetch_inst_o),
    .data_rvalid_o  (data_rvalid_o),
    .data_rdata_o   (data_rdata_o),
    .data_wdone_o   (data_wdone_o)
  );

endmodule

// ==== src/mem_req_arbiter.sv ====
module mem_req_arbiter
  import rv_core_pkg::*, axi_bus_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      fetch_req_i,
  input  pc_t       fetch_pc_i,
  input  logic      data_rd_req_i,
  input  logic      data_wr_req_i,
  input  pc_t       data_addr_i,
  input  axi_data_t data_wdata_i,
  input  axi_strb_t data_wstrb_i,
  input  logic      rd_done_i,
  input  logic      wr_done_i,
  output logic      fetch_grant_o,
  output logic      data_grant_o,
  output logic      req_valid_o,
  output req_kind_e req_kind_o,
  output req_id_t   req_id_o,
  output axi_addr_t req_addr_o,
  output axi_data_t req_wdata_o,
  output axi_strb_t req_wstrb_o
);

  logic      busy_q;
  logic      data_served_q;
  logic      req_valid_q;
  req_kind_e req_kind_q;
  req_id_t   req_id_q;
  axi_addr_t req_addr_q;
  axi_data_t req_wdata_q;
  axi_strb_t req_wstrb_q;
  logic      data_req;
  logic      data_win;
  logic      fetch_win;

  assign data_req  = data_rd_req_i | data_wr_req_i;
  // data has fixed priority, held level served only once
  assign data_win  = ~busy_q & data_req & ~data_served_q;
  assign fetch_win = ~busy_q & fetch_req_i & ~data_win;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q        <= 1'b0;
      data_served_q <= 1'b0;
      req_valid_q   <= 1'b0;
      req_kind_q    <= req_none;
    end else begin
      // launch pulse for the bridge
      req_valid_q <= data_win | fetch_win;
      if (data_win || fetch_win) begin
        busy_q <= 1'b1;
      end else if (rd_done_i || wr_done_i) begin
        busy_q <= 1'b0;
      end
      // rearm once the requester drops its level
      if (data_win) begin
        data_served_q <= 1'b1;
      end else if (!data_req) begin
        data_served_q <= 1'b0;
      end
      if (data_win) begin
        req_kind_q <= data_wr_req_i ? req_data_wr : req_data_rd;
      end else if (fetch_win) begin
        req_kind_q <= req_fetch_rd;
      end else if (rd_done_i || wr_done_i) begin
        req_kind_q <= req_none;
      end
    end
  end

  // request payload, stable for the whole transaction
  always_ff @(posedge clk) begin
    if (data_win) begin
      req_id_q    <= req_id_data;
      req_addr_q  <= data_addr_i;
      req_wdata_q <= data_wdata_i;
      req_wstrb_q <= data_wstrb_i;
    end else if (fetch_win) begin
      req_id_q    <= req_id_fetch;
      req_addr_q  <= fetch_pc_i;
      req_wdata_q <= '0;
      req_wstrb_q <= '0;
    end
  end

  assign fetch_grant_o = fetch_win;
  assign data_grant_o  = data_win;
  assign req_valid_o   = req_valid_q;
  assign req_kind_o    = req_kind_q;
  assign req_id_o      = req_id_q;
  assign req_addr_o    = req_addr_q;
  assign req_wdata_o   = req_wdata_q;
  assign req_wstrb_o   = req_wstrb_q;

endmodule

// ==== src/pc_sequencer.sv ====
`include "fetch_cfg.svh"

module pc_sequencer
  import rv_core_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic fetch_en_i,
  input  logic redirect_i,
  input  pc_t  redirect_pc_i,
  input  logic fetch_grant_i,
  input  logic fetch_accept_i,
  output logic fetch_req_o,
  output pc_t  fetch_pc_o,
  output logic kill_o
);

  pc_t  pc_q;
  logic pending_q;
  logic kill_q;

  // redirect wins over sequential advance
  // a killed response must not bump the new pc
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q <= `FETCH_RESET_PC;
    end else if (redirect_i) begin
      pc_q <= redirect_pc_i;
    end else if (fetch_accept_i && !kill_q) begin
      pc_q <= pc_q + 64'd4;
    end
  end

  // one fetch on the bus at a time
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending_q <= 1'b0;
    end else if (fetch_grant_i) begin
      pending_q <= 1'b1;
    end else if (fetch_accept_i) begin
      pending_q <= 1'b0;
    end
  end

  // stale fetch marker, cleared once that fetch comes back
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      kill_q <= 1'b0;
    end else if (fetch_accept_i) begin
      kill_q <= 1'b0;
    end else if (redirect_i && pending_q) begin
      kill_q <= 1'b1;
    end
  end

  // no request in the redirect cycle, pc is about to change
  assign fetch_req_o = fetch_en_i & ~pending_q & ~redirect_i;
  assign fetch_pc_o  = pc_q;
  // router may see rd_done in the redirect cycle itself
  assign kill_o      = kill_q | (redirect_i & pending_q);

endmodule

// ==== src/resp_router.sv ====
`include "fetch_cfg.svh"

module resp_router
  import rv_core_pkg::*, axi_bus_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      rd_done_i,
  input  axi_data_t rd_data_i,
  input  req_id_t   rd_id_i,
  input  logic      wr_done_i,
  input  logic      kill_i,
  input  pc_t       fetch_pc_i,
  output logic      fetch_accept_o,
  output logic      fetch_valid_o,
  output pc_t       fetch_pc_o,
  output inst_t     fetch_inst_o,
  output logic      data_rvalid_o,
  output axi_data_t data_rdata_o,
  output logic      data_wdone_o
);

  logic      fetch_done;
  logic      data_done;
  logic      fetch_accept_q;
  logic      fetch_valid_q;
  logic      data_rvalid_q;
  logic      data_wdone_q;
  pc_t       fetch_pc_q;
  inst_t     inst_q;
  axi_data_t data_q;

  // steer by tag
  assign fetch_done = rd_done_i & (rd_id_i == req_id_fetch);
  assign data_done  = rd_done_i & (rd_id_i == req_id_data);

  // delayed done pulses
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetch_accept_q <= 1'b0;
      fetch_valid_q  <= 1'b0;
      data_rvalid_q  <= 1'b0;
      data_wdone_q   <= 1'b0;
    end else begin
      // killed fetch still retires, just invisible
      fetch_accept_q <= fetch_done;
      fetch_valid_q  <= fetch_done & ~kill_i;
      data_rvalid_q  <= data_done;
      data_wdone_q   <= wr_done_i;
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_done) begin
      fetch_pc_q <= fetch_pc_i;
      // pc bit 2 picks the upper word half
      inst_q     <= fetch_pc_i[2] ? rd_data_i[63:32] : rd_data_i[31:0];
    end
    if (data_done) begin
      data_q <= rd_data_i;
    end
  end

  assign fetch_accept_o = fetch_accept_q;
  assign fetch_valid_o  = fetch_valid_q;
  assign fetch_pc_o     = fetch_pc_q;
  // nop whenever no valid fetch is presented
  assign fetch_inst_o   = fetch_valid_q ? inst_q : `FETCH_NOP_INST;
  assign data_rvalid_o  = data_rvalid_q;
  assign data_rdata_o   = data_q;
  assign data_wdone_o   = data_wdone_q;

endmodule

// ==== tests/tb_fetch_stage.sv ====
`include "fetch_cfg.svh"

module tb_fetch_stage
  import rv_core_pkg::*, axi_bus_pkg::*;
();

  // run limit about four times what the five tests need
  localparam int max_cycles  = 2000;
  // per-transaction and per-fetch-burst wait limits
  localparam int done_limit  = 40;
  localparam int fetch_limit = 200;

  logic      clk;
  logic      rst_n;
  logic      fetch_en_i;
  logic      redirect_i;
  pc_t       redirect_pc_i;
  logic      data_rd_req_i;
  logic      data_wr_req_i;
  pc_t       data_addr_i;
  axi_data_t data_wdata_i;
  axi_strb_t data_wstrb_i;
  logic      fetch_valid_o;
  pc_t       fetch_pc_o;
  inst_t     fetch_inst_o;
  logic      data_rvalid_o;
  axi_data_t data_rdata_o;
  logic      data_wdone_o;

  // model of the sram indexed like the slave by addr[12:3]
  axi_data_t model_mem [`FETCH_MEM_WORDS];

  // fetches seen by the last collect
  pc_t   got_pc [8];
  inst_t got_inst [8];
  int    got_count;

  string cur_test;
  int    err_count;
  int    tests_run;
  int    tests_failed;
  int    cycle_count;

  fetch_stage_top dut_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch_en_i    (fetch_en_i),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .data_rd_req_i (data_rd_req_i),
    .data_wr_req_i (data_wr_req_i),
    .data_addr_i   (data_addr_i),
    .data_wdata_i  (data_wdata_i),
    .data_wstrb_i  (data_wstrb_i),
    .fetch_valid_o (fetch_valid_o),
    .fetch_pc_o    (fetch_pc_o),
    .fetch_inst_o  (fetch_inst_o),
    .data_rvalid_o (data_rvalid_o),
    .data_rdata_o  (data_rdata_o),
    .data_wdone_o  (data_wdone_o)
  );

  always #2 clk = ~clk;

  // watchdog
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= max_cycles) begin
      $display("run stopped, no finish after %0d cycles", max_cycles);
      $display("Test FAILED");
      $finish;
    end
  end

  function automatic int word_idx(input pc_t addr);
    return int'(addr[12:3]);
  endfunction

  // bytes under a set strobe bit take the new value
  function automatic axi_data_t merge_bytes(input axi_data_t old_d, input axi_data_t new_d,
                                            input axi_strb_t strb);
    axi_data_t res;
    res = old_d;
    for (int i = 0; i < 8; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = new_d[8*i +: 8];
      end
    end
    return res;
  endfunction

  // pc bit 2 picks the upper half of the word
  function automatic inst_t expect_inst(input pc_t pc);
    axi_data_t w;
    w = model_mem[word_idx(pc)];
    return pc[2] ? w[63:32] : w[31:0];
  endfunction

  task automatic check_pc(input string what, input pc_t exp, input pc_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: %s expected %h actual %h", cur_test, what, exp, act);
      err_count++;
    end
  endtask

  task automatic check_inst(input string what, input inst_t exp, input inst_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: %s expected %h actual %h", cur_test, what, exp, act);
      err_count++;
    end
  endtask

  task automatic check_data(input string what, input axi_data_t exp, input axi_data_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: %s expected %h actual %h", cur_test, what, exp, act);
      err_count++;
    end
  endtask

  // level held until the write-done pulse and dropped afterwards
  task automatic write_word(input pc_t addr, input axi_data_t data, input axi_strb_t strb);
    int waited;
    waited = 0;
    @(posedge clk);
    #1;
    data_wr_req_i = 1'b1;
    data_addr_i   = addr;
    data_wdata_i  = data;
    data_wstrb_i  = strb;
    do begin
      @(negedge clk);
      waited++;
    end while (!data_wdone_o && waited < done_limit);
    if (!data_wdone_o) begin
      $display("ERROR %s: write to %h never completed", cur_test, addr);
      err_count++;
    end
    @(posedge clk);
    #1;
    data_wr_req_i = 1'b0;
    model_mem[word_idx(addr)] = merge_bytes(model_mem[word_idx(addr)], data, strb);
  endtask

  task automatic read_word(input pc_t addr, output axi_data_t data);
    int waited;
    waited = 0;
    @(posedge clk);
    #1;
    data_rd_req_i = 1'b1;
    data_addr_i   = addr;
    do begin
      @(negedge clk);
      waited++;
    end while (!data_rvalid_o && waited < done_limit);
    if (!data_rvalid_o) begin
      $display("ERROR %s: read from %h never completed", cur_test, addr);
      err_count++;
    end
    data = data_rdata_o;
    @(posedge clk);
    #1;
    data_rd_req_i = 1'b0;
  endtask

  task automatic read_and_check(input pc_t addr);
    axi_data_t got;
    read_word(addr, got);
    check_data($sformatf("read at %h", addr), model_mem[word_idx(addr)], got);
  endtask

  task automatic preload_words(input pc_t base, input int count);
    pc_t addr;
    addr = base;
    for (int k = 0; k < count; k++) begin
      write_word(addr, {$urandom(), $urandom()}, 8'hff);
      addr = addr + 64'd8;
    end
  endtask

  // fetch disabled here so no kill is raised
  task automatic set_pc(input pc_t pc);
    @(posedge clk);
    #1;
    redirect_i    = 1'b1;
    redirect_pc_i = pc;
    @(posedge clk);
    #1;
    redirect_i = 1'b0;
  endtask

  // dropping enable right after the last pulse keeps another fetch from issuing
  task automatic collect_fetches(input int count, input bit stop);
    int waited;
    waited    = 0;
    got_count = 0;
    while (got_count < count && waited < fetch_limit) begin
      @(negedge clk);
      waited++;
      if (fetch_valid_o) begin
        got_pc[got_count]   = fetch_pc_o;
        got_inst[got_count] = fetch_inst_o;
        got_count++;
      end else begin
        // idle or killed slots show a nop
        check_inst("idle instruction", `FETCH_NOP_INST, fetch_inst_o);
      end
    end
    if (got_count < count) begin
      $display("ERROR %s: only %0d of %0d fetches arrived", cur_test, got_count, count);
      err_count++;
    end
    if (stop) begin
      @(posedge clk);
      #1;
      fetch_en_i = 1'b0;
    end
  endtask

  // gapless pc run from base with each half word
  task automatic check_fetches(input pc_t base);
    pc_t exp_pc;
    exp_pc = base;
    for (int i = 0; i < got_count; i++) begin
      check_pc($sformatf("fetch %0d pc", i), exp_pc, got_pc[i]);
      check_inst($sformatf("fetch %0d inst", i), expect_inst(exp_pc), got_inst[i]);
      exp_pc = exp_pc + 64'd4;
    end
  endtask

  task automatic end_test(input int errs_before);
    tests_run++;
    if (err_count == errs_before) begin
      $display("test %s: pass", cur_test);
    end else begin
      tests_failed++;
      $display("test %s: fail with %0d errors", cur_test, err_count - errs_before);
    end
  endtask

  task automatic test_write_read();
    int  errs;
    pc_t addr;
    errs     = err_count;
    cur_test = "write_read";
    addr     = `FETCH_RESET_PC + 64'h100;
    for (int i = 0; i < 5; i++) begin
      write_word(addr, {$urandom(), $urandom()}, 8'hff);
      addr = addr + 64'h18;
    end
    addr = `FETCH_RESET_PC + 64'h100;
    for (int i = 0; i < 5; i++) begin
      read_and_check(addr);
      addr = addr + 64'h18;
    end
    end_test(errs);
  endtask

  task automatic test_strobe_merge();
    int  errs;
    pc_t addr;
    errs     = err_count;
    cur_test = "strobe_merge";
    addr     = `FETCH_RESET_PC + 64'h180;
    write_word(addr, {$urandom(), $urandom()}, 8'hff);
    // two partial rewrites merged onto what is there
    write_word(addr, {$urandom(), $urandom()}, 8'h5a);
    read_and_check(addr);
    write_word(addr, {$urandom(), $urandom()}, 8'h81);
    read_and_check(addr);
    end_test(errs);
  endtask

  task automatic test_seq_fetch();
    int errs;
    errs     = err_count;
    cur_test = "seq_fetch";
    preload_words(`FETCH_RESET_PC, 4);
    // pc still at its reset value
    @(posedge clk);
    #1;
    fetch_en_i = 1'b1;
    collect_fetches(8, 1'b1);
    check_fetches(`FETCH_RESET_PC);
    end_test(errs);
  endtask

  task automatic test_redirect();
    int  errs;
    pc_t start_pc;
    pc_t target;
    errs     = err_count;
    cur_test = "redirect";
    start_pc = `FETCH_RESET_PC + 64'h40;
    // odd word slot makes the first target fetch use the high half
    target   = `FETCH_RESET_PC + 64'h204;
    preload_words(start_pc, 2);
    preload_words(`FETCH_RESET_PC + 64'h200, 2);
    set_pc(start_pc);
    @(posedge clk);
    #1;
    fetch_en_i = 1'b1;
    collect_fetches(1, 1'b0);
    check_fetches(start_pc);
    // next fetch is granted two edges on and the redirect hits it in flight
    @(posedge clk);
    #1;
    @(posedge clk);
    #1;
    redirect_i    = 1'b1;
    redirect_pc_i = target;
    @(posedge clk);
    #1;
    redirect_i = 1'b0;
    collect_fetches(3, 1'b1);
    check_fetches(target);
    end_test(errs);
  endtask

  task automatic test_data_priority();
    int  errs;
    pc_t base;
    pc_t data_base;
    errs      = err_count;
    cur_test  = "data_priority";
    base      = `FETCH_RESET_PC + 64'h80;
    data_base = `FETCH_RESET_PC + 64'h300;
    preload_words(base, 3);
    preload_words(data_base, 3);
    set_pc(base);
    @(posedge clk);
    #1;
    fetch_en_i = 1'b1;
    // fetch stream and data reads compete for the bus
    fork
      collect_fetches(6, 1'b1);
      begin
        read_and_check(data_base);
        read_and_check(data_base + 64'h8);
        read_and_check(data_base + 64'h10);
      end
    join
    check_fetches(base);
    end_test(errs);
  endtask

  initial begin
    void'($urandom(19483));
    clk           = 1'b0;
    rst_n         = 1'b0;
    fetch_en_i    = 1'b0;
    redirect_i    = 1'b0;
    redirect_pc_i = '0;
    data_rd_req_i = 1'b0;
    data_wr_req_i = 1'b0;
    data_addr_i   = '0;
    data_wdata_i  = '0;
    data_wstrb_i  = '0;
    err_count     = 0;
    tests_run     = 0;
    tests_failed  = 0;
    cycle_count   = 0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    test_write_read();
    test_strobe_merge();
    test_seq_fetch();
    test_redirect();
    test_data_priority();

    $display("tests run %0d, tests failed %0d, check errors %0d",
             tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
